//--- filelist.f
+incdir+verilog
verilog/gpu_pkg.sv
verilog/qspi_sequencer.sv
verilog/pixel_writer.sv
verilog/palette_store.sv
verilog/response_shifter.sv
verilog/qspi_gpu_top.sv
testbench/tb_clock.sv
testbench/tb_qspi_gpu.sv

//--- testbench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock
#(
    parameter int half_period = 5   // ns, gives a 10 ns sclk
)
(
    output logic sclk
);

    initial
    begin
        sclk = 1'b0;
        forever
            #(half_period) sclk = ~sclk;
    end

endmodule

`default_nettype wire

//--- testbench/tb_qspi_gpu.sv
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module tb_qspi_gpu;

    localparam int max_rows    = 24;
    localparam int gap_cycles  = 2;    // cs high between transactions
    localparam int pal_nibbles = `GPU_PALETTE_DEPTH * `GPU_NIBBLES_PER_ENTRY;

    logic              sclk;
    logic              rst;
    logic              cs;
    gpu_pkg::nibble_t  data_in;
    gpu_pkg::nibble_t  data_out;
    logic              data_oe;
    logic              hblank;
    logic              vblank;
    gpu_pkg::fb_addr_t fb_addr;
    gpu_pkg::pixel_t   fb_data;
    logic              fb_wr;
    logic              output_enabled;

    // transaction table, one entry per row
    logic [7:0]          t_cmd      [max_rows];
    int                  t_pay_len  [max_rows];
    logic [63:0]         t_payload  [max_rows];   // nibble 0 in the top bits
    logic                t_use_pal  [max_rows];   // payload or reply taken from pal_model
    int                  t_resp_len [max_rows];
    gpu_pkg::resp_word_t t_exp      [max_rows];
    logic                t_hb       [max_rows];
    logic                t_vb       [max_rows];
    logic                t_oe       [max_rows];   // output_enabled after the row
    int                  n_rows;

    gpu_pkg::rgb_t       pal_model [`GPU_PALETTE_DEPTH];
    gpu_pkg::fb_addr_t   log_addr [$];
    gpu_pkg::pixel_t     log_data [$];
    gpu_pkg::fb_addr_t   exp_addr [$];
    gpu_pkg::pixel_t     exp_data [$];
    logic                prev_wr;
    integer              seed;
    int                  cycle_count;
    int                  cycle_limit;
    int                  fail_count;

    tb_clock clk_gen_i (.sclk(sclk));

    qspi_gpu_top dut_i
    (
        .sclk           (sclk),
        .rst            (rst),
        .cs             (cs),
        .data_in        (data_in),
        .data_out       (data_out),
        .data_oe        (data_oe),
        .hblank         (hblank),
        .vblank         (vblank),
        .fb_addr        (fb_addr),
        .fb_data        (fb_data),
        .fb_wr          (fb_wr),
        .output_enabled (output_enabled)
    );

    always @(posedge sclk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout after %0d cycles, the transactions did not finish", cycle_count);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_run(input string why);
        fail_count++;
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_nibble(input string name, input gpu_pkg::nibble_t got,
                                input gpu_pkg::nibble_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_word(input string name, input gpu_pkg::resp_word_t got,
                              input gpu_pkg::resp_word_t exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_pixel(input gpu_pkg::fb_addr_t got_addr, input gpu_pkg::fb_addr_t exp_a,
                               input gpu_pkg::pixel_t got_data, input gpu_pkg::pixel_t exp_d);
        if (got_addr !== exp_a)
            stop_run($sformatf("MISMATCH fb_addr got %h expected %h", got_addr, exp_a));
        else if (got_data !== exp_d)
            stop_run($sformatf("MISMATCH fb_data got %h expected %h", got_data, exp_d));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    function automatic gpu_pkg::resp_word_t status_word(input logic hb, input logic vb,
                                                        input logic oe);
        status_word = {8'h00, `GPU_STATUS_ID, hb, vb, oe};
    endfunction

    // nibble i of a row, high nibble first
    function automatic gpu_pkg::nibble_t payload_nibble(input int r, input int i);
        gpu_pkg::rgb_t entry;
        logic [63:0]   word;
        entry = pal_model[i / `GPU_NIBBLES_PER_ENTRY] >>
                (4 * (`GPU_NIBBLES_PER_ENTRY - 1 - i % `GPU_NIBBLES_PER_ENTRY));
        word  = t_payload[r] >> (60 - 4 * i);
        payload_nibble = t_use_pal[r] ? entry[3:0] : word[3:0];
    endfunction

    function automatic int row_cycles(input int r);
        int body;
        body = t_pay_len[r];
        if (`GPU_DUMMY_CYCLES + t_resp_len[r] > body)
            body = `GPU_DUMMY_CYCLES + t_resp_len[r];
        row_cycles = 2 + body;
    endfunction

    task automatic add_row(input logic [7:0] cmd, input int pay_len, input logic [63:0] payload,
                           input logic use_pal, input int resp_len,
                           input gpu_pkg::resp_word_t exp, input logic hb, input logic vb,
                           input logic oe);
        t_cmd[n_rows]      = cmd;
        t_pay_len[n_rows]  = pay_len;
        t_payload[n_rows]  = payload;
        t_use_pal[n_rows]  = use_pal;
        t_resp_len[n_rows] = resp_len;
        t_exp[n_rows]      = exp;
        t_hb[n_rows]       = hb;
        t_vb[n_rows]       = vb;
        t_oe[n_rows]       = oe;
        n_rows++;
    endtask

    task automatic build_table();
        int hv;
        n_rows = 0;
        add_row(gpu_pkg::cmd_read_magic, 0, '0, 0, 4, `GPU_MAGIC_NUMBER, 0, 0, 0);
        for (hv = 0; hv < 4; hv++)
            add_row(gpu_pkg::cmd_read_status0, 0, '0, 0, 2, status_word(hv[1], hv[0], 0),
                    hv[1], hv[0], 0);
        add_row(gpu_pkg::cmd_enable_output, 0, '0, 0, 0, '0, 0, 0, 1);
        for (hv = 0; hv < 4; hv++)
            add_row(gpu_pkg::cmd_read_status0, 0, '0, 0, 2, status_word(hv[1], hv[0], 1),
                    hv[1], hv[0], 1);
        add_row(gpu_pkg::cmd_disable_output, 0, '0, 0, 0, '0, 0, 0, 0);
        for (hv = 0; hv < 4; hv++)
            add_row(gpu_pkg::cmd_read_status0, 0, '0, 0, 2, status_word(hv[1], hv[0], 0),
                    hv[1], hv[0], 0);
        add_row(gpu_pkg::cmd_enable_output, 0, '0, 0, 0, '0, 0, 0, 1);
        add_row(gpu_pkg::cmd_set_palette, pal_nibbles, '0, 1, 0, '0, 0, 0, 1);
        add_row(gpu_pkg::cmd_get_palette, 0, '0, 1, pal_nibbles, '0, 0, 0, 1);
        // start 76798, then pixels 3c a7 51 e8 across the wrap
        add_row(gpu_pkg::cmd_fb_continuous_write, 13, 64'h12BF_E3CA_751E_8000, 0, 0, '0,
                0, 0, 1);
        add_row(8'hFF, 6, 64'h8240_3C00_0000_0000, 0, 0, '0, 1, 1, 1);   // undefined
        add_row(gpu_pkg::cmd_get_palette, 0, '0, 1, pal_nibbles, '0, 0, 0, 1);
        add_row(gpu_pkg::cmd_read_status0, 0, '0, 0, 2, status_word(1, 1, 1), 1, 1, 1);
    endtask

    // address advances per pixel and wraps after the last one
    task automatic expect_fb_writes(input int r);
        gpu_pkg::fb_addr_t a;
        logic [63:0]       word;
        int                p;
        word = t_payload[r];
        a    = word[60:44];
        for (p = `GPU_ADDR_NIBBLES; p + 1 < t_pay_len[r]; p += 2)
        begin
            exp_addr.push_back(a);
            exp_data.push_back({payload_nibble(r, p), payload_nibble(r, p + 1)});
            a = (a == `GPU_FB_PIXELS - 1) ? '0 : a + 17'd1;
        end
    endtask

    task automatic next_cycle();
        @(posedge sclk);
        #1;
        if (fb_wr)
        begin
            if (prev_wr)
                stop_run($sformatf("fb_wr stayed high for two cycles at fb_addr %h", fb_addr));
            log_addr.push_back(fb_addr);
            log_data.push_back(fb_data);
        end
        prev_wr = fb_wr;
    endtask

    task automatic run_row(input int r);
        gpu_pkg::resp_word_t word;
        int                  n;
        int                  j;
        word = '0;
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
        if (t_cmd[r] == gpu_pkg::cmd_fb_continuous_write)
            expect_fb_writes(r);
        hblank  = t_hb[r];
        vblank  = t_vb[r];
        cs      = 1'b0;
        data_in = t_cmd[r][7:4];
        for (n = 0; n < row_cycles(r); n++)
        begin
            next_cycle();
            j = n - 3;   // reply nibble registered on edge n
            if (j >= 0 && j < t_resp_len[r])
            begin
                check_flag("data_oe", data_oe, 1'b1);
                if (t_use_pal[r])
                    check_nibble("data_out", data_out, payload_nibble(r, j));
                else
                    word = {word[11:0], data_out};
            end
            else if (t_resp_len[r] == 0 || j < 0 || !t_use_pal[r])
                check_flag("data_oe", data_oe, 1'b0);
            if (n == 0)
                data_in = t_cmd[r][3:0];
            else if (n - 1 < t_pay_len[r])
                data_in = payload_nibble(r, n - 1);   // sampled on edge n+1
            else
                data_in = 4'h0;
        end
        cs      = 1'b1;
        data_in = 4'h0;
        if (t_resp_len[r] > 0 && !t_use_pal[r])
            check_word("response word", word, t_exp[r]);
        for (n = 0; n < gap_cycles; n++)
            next_cycle();
        check_flag("output_enabled", output_enabled, t_oe[r]);
        if (log_addr.size() != exp_addr.size())
            stop_run($sformatf("row %0d gave %0d fb_wr strobes where %0d were expected",
                               r, log_addr.size(), exp_addr.size()));
        for (j = 0; j < exp_addr.size(); j++)
            check_pixel(log_addr[j], exp_addr[j], log_data[j], exp_data[j]);
    endtask

    initial
    begin
        int r;
        seed        = 32'h28b1_0928;
        rst         = 1'b1;
        cs          = 1'b1;
        data_in     = 4'h0;
        hblank      = 1'b0;
        vblank      = 1'b0;
        prev_wr     = 1'b0;
        fail_count  = 0;
        cycle_count = 0;
        for (r = 0; r < `GPU_PALETTE_DEPTH; r++)
            pal_model[r] = $random(seed);
        build_table();
        cycle_limit = 3 + 20;   // reset, first check and margin
        for (r = 0; r < n_rows; r++)
            cycle_limit += row_cycles(r) + gap_cycles;

        repeat (2) @(posedge sclk);
        #1;
        rst = 1'b0;
        next_cycle();
        check_flag("data_oe", data_oe, 1'b0);
        check_flag("fb_wr", fb_wr, 1'b0);
        check_flag("output_enabled", output_enabled, 1'b0);

        for (r = 0; r < n_rows; r++)
            run_row(r);

        if (fail_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/gpu_macros.svh
`ifndef GPU_MACROS_SVH
`define GPU_MACROS_SVH

// value returned by the magic number command
`define GPU_MAGIC_NUMBER 16'hA5C3

// turnaround cycles between the command and a write phase
`define GPU_DUMMY_CYCLES 2

// palette entries, one rgb colour each
`define GPU_PALETTE_DEPTH 256

// 320x240 framebuffer, pixel address wraps to 0 after the last one
`define GPU_FB_PIXELS 76800

// fixed top bits of status register 0
`define GPU_STATUS_ID 5'b10110

// 24-bit colour sent as nibbles
`define GPU_NIBBLES_PER_ENTRY 6

// 20-bit start address field of the framebuffer write
`define GPU_ADDR_NIBBLES 5

`endif

//--- verilog/gpu_pkg.sv
`default_nettype none

package gpu_pkg;

    typedef logic [3:0]  nibble_t;    // one quad-spi bus transfer
    typedef logic [7:0]  pixel_t;
    typedef logic [16:0] fb_addr_t;
    typedef logic [7:0]  pal_index_t;
    typedef logic [23:0] rgb_t;
    typedef logic [15:0] resp_word_t;
    typedef logic [15:0] count_t;     // nibbles seen within a phase

    // bit 7 marks a read phase, bit 6 a write phase
    typedef enum logic [7:0]
    {
        cmd_fb_continuous_write = 8'b1000_0010,
        cmd_set_palette         = 8'b1000_0011,
        cmd_get_palette         = 8'b0100_0011,
        cmd_read_status0        = 8'b0100_0000,
        cmd_read_magic          = 8'b0110_0000,
        cmd_disable_output      = 8'b0000_0000,
        cmd_enable_output       = 8'b0000_0001
    } command_t;

    typedef enum logic [2:0]
    {
        ph_idle,
        ph_command,
        ph_read,
        ph_write_dummy,
        ph_write,
        ph_done
    } phase_t;

endpackage

`default_nettype wire

//--- verilog/palette_store.sv
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module palette_store
(
    input  wire logic             sclk,
    input  wire logic             rst,
    input  wire logic             pal_load,
    input  wire logic             pal_stream,
    input  wire gpu_pkg::count_t  phase_count,
    input  wire gpu_pkg::nibble_t rd_nibble,
    output gpu_pkg::nibble_t      pal_nibble
);

    localparam logic [2:0] last_sub = 3'(`GPU_NIBBLES_PER_ENTRY - 1);

    gpu_pkg::rgb_t      mem [`GPU_PALETTE_DEPTH];
    gpu_pkg::pal_index_t wr_idx;
    gpu_pkg::rgb_t      asm_word;    // entry being collected
    logic [2:0]         ld_sub;
    logic [2:0]         ld_pos;
    gpu_pkg::rgb_t      asm_next;

    gpu_pkg::pal_index_t rd_idx;
    gpu_pkg::rgb_t      rd_data;     // prefetched entry
    gpu_pkg::rgb_t      out_sh;
    logic [2:0]         rd_sub;

    // first nibble of a set phase always starts an entry
    assign ld_pos   = (phase_count == '0) ? 3'd0 : ld_sub;
    assign asm_next = {asm_word[19:0], rd_nibble};

    always_ff @(posedge sclk)
    begin
        if (rst)
        begin
            wr_idx <= '0;
            ld_sub <= '0;
        end
        else if (pal_load)
        begin
            asm_word <= asm_next;
            if (ld_pos == last_sub)
            begin
                mem[wr_idx] <= asm_next;   // one cycle after the sixth nibble
                wr_idx      <= wr_idx + 8'd1;
                ld_sub      <= '0;
            end
            else
                ld_sub <= ld_pos + 3'd1;
        end
        else
        begin
            wr_idx <= '0;
            ld_sub <= '0;
        end
    end

    // synchronous read, refreshed every cycle
    always_ff @(posedge sclk)
    begin
        rd_data <= mem[rd_idx];
    end

    // fresh entry comes straight from the prefetch register
    assign pal_nibble = (rd_sub == 3'd0) ? rd_data[23:20] : out_sh[23:20];

    always_ff @(posedge sclk)
    begin
        if (rst)
        begin
            rd_idx <= '0;
            rd_sub <= '0;
        end
        else if (pal_stream)
        begin
            if (rd_sub == 3'd0)
            begin
                out_sh <= {rd_data[19:0], 4'h0};
                rd_idx <= rd_idx + 8'd1;        // fetch the following entry
            end
            else
                out_sh <= {out_sh[19:0], 4'h0};
            rd_sub <= (rd_sub == last_sub) ? 3'd0 : rd_sub + 3'd1;
        end
        else
        begin
            rd_idx <= '0;   // entry 0 gets fetched during the dummy cycles
            rd_sub <= '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pixel_writer.sv
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module pixel_writer
(
    input  wire logic             sclk,
    input  wire logic             rst,
    input  wire logic             pix_load,
    input  wire gpu_pkg::count_t  phase_count,
    input  wire gpu_pkg::nibble_t rd_nibble,
    output gpu_pkg::fb_addr_t     fb_addr,
    output gpu_pkg::pixel_t       fb_data,
    output logic                  fb_wr
);

    localparam gpu_pkg::fb_addr_t last_pixel = 17'(`GPU_FB_PIXELS - 1);

    logic [15:0]        addr_sh;     // first four address nibbles
    logic [19:0]        start_word;
    gpu_pkg::fb_addr_t  next_addr;   // address of the next pixel to write
    gpu_pkg::nibble_t   pix_hi;
    gpu_pkg::count_t    pair_pos;    // nibble position after the address field

    assign start_word = {addr_sh, rd_nibble};
    assign pair_pos   = phase_count - gpu_pkg::count_t'(`GPU_ADDR_NIBBLES);

    always_ff @(posedge sclk)
    begin
        if (rst)
        begin
            fb_wr     <= 1'b0;
            next_addr <= '0;
        end
        else
        begin
            fb_wr <= 1'b0;
            if (pix_load)
            begin
                if (phase_count < gpu_pkg::count_t'(`GPU_ADDR_NIBBLES))
                begin
                    addr_sh <= start_word[15:0];
                    if (phase_count == gpu_pkg::count_t'(`GPU_ADDR_NIBBLES - 1))
                    begin
                        // out of range start falls back to the first pixel
                        if (start_word[16:0] <= last_pixel)
                            next_addr <= start_word[16:0];
                        else
                            next_addr <= '0;
                    end
                end
                else if (!pair_pos[0])
                    pix_hi <= rd_nibble;                  // high nibble of pixel
                else
                begin
                    fb_addr   <= next_addr;
                    fb_data   <= {pix_hi, rd_nibble};
                    fb_wr     <= 1'b1;
                    next_addr <= (next_addr == last_pixel) ? '0 : next_addr + 17'd1;
                end
            end
        end
    end

    assert property (@(posedge sclk) disable iff (rst) fb_wr |=> !fb_wr);

    assert property (@(posedge sclk) disable iff (rst)
        fb_wr |-> fb_addr < 17'(`GPU_FB_PIXELS));

endmodule

`default_nettype wire

//--- verilog/qspi_gpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module qspi_gpu_top
(
    input  wire logic             sclk,
    input  wire logic             rst,
    input  wire logic             cs,
    input  wire gpu_pkg::nibble_t data_in,
    output gpu_pkg::nibble_t      data_out,
    output logic                  data_oe,
    input  wire logic             hblank,
    input  wire logic             vblank,
    output gpu_pkg::fb_addr_t     fb_addr,
    output gpu_pkg::pixel_t       fb_data,
    output logic                  fb_wr,
    output logic                  output_enabled
);

    gpu_pkg::count_t  phase_count;
    gpu_pkg::nibble_t rd_nibble;
    gpu_pkg::nibble_t pal_nibble;
    logic             pix_load;
    logic             pal_load;
    logic             pal_stream;
    logic             resp_status;
    logic             resp_magic;

    qspi_sequencer u_sequencer
    (
        .sclk           (sclk),
        .rst            (rst),
        .cs             (cs),
        .data_in        (data_in),
        .phase_count    (phase_count),
        .rd_nibble      (rd_nibble),
        .pix_load       (pix_load),
        .pal_load       (pal_load),
        .pal_stream     (pal_stream),
        .resp_status    (resp_status),
        .resp_magic     (resp_magic),
        .output_enabled (output_enabled)
    );

    pixel_writer u_pixel_writer
    (
        .sclk        (sclk),
        .rst         (rst),
        .pix_load    (pix_load),
        .phase_count (phase_count),
        .rd_nibble   (rd_nibble),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .fb_wr       (fb_wr)
    );

    palette_store u_palette_store
    (
        .sclk        (sclk),
        .rst         (rst),
        .pal_load    (pal_load),
        .pal_stream  (pal_stream),
        .phase_count (phase_count),
        .rd_nibble   (rd_nibble),
        .pal_nibble  (pal_nibble)
    );

    response_shifter u_response_shifter
    (
        .sclk           (sclk),
        .rst            (rst),
        .resp_status    (resp_status),
        .resp_magic     (resp_magic),
        .pal_stream     (pal_stream),
        .phase_count    (phase_count),
        .hblank         (hblank),
        .vblank         (vblank),
        .output_enabled (output_enabled),
        .pal_nibble     (pal_nibble),
        .data_out       (data_out),
        .data_oe        (data_oe)
    );

endmodule

`default_nettype wire

//--- verilog/qspi_sequencer.sv
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module qspi_sequencer
(
    input  wire logic             sclk,
    input  wire logic             rst,
    input  wire logic             cs,
    input  wire gpu_pkg::nibble_t data_in,
    output gpu_pkg::count_t       phase_count,
    output gpu_pkg::nibble_t      rd_nibble,
    output logic                  pix_load,
    output logic                  pal_load,
    output logic                  pal_stream,
    output logic                  resp_status,
    output logic                  resp_magic,
    output logic                  output_enabled
);

    // index of the final response nibble for the fixed-length replies
    localparam gpu_pkg::count_t status_last = 16'd1;
    localparam gpu_pkg::count_t magic_last  = 16'd3;

    gpu_pkg::phase_t state, next_state;
    gpu_pkg::count_t cnt, next_cnt;
    logic [7:0]      cmd_bits;
    logic [7:0]      full_cmd;     // command as it completes on edge n=1
    logic            cmd_known;
    gpu_pkg::command_t cmd;

    assign cmd      = gpu_pkg::command_t'(cmd_bits);
    assign full_cmd = {cmd_bits[3:0], data_in};

    always_comb
    begin
        case (full_cmd)
            gpu_pkg::cmd_fb_continuous_write,
            gpu_pkg::cmd_set_palette,
            gpu_pkg::cmd_get_palette,
            gpu_pkg::cmd_read_status0,
            gpu_pkg::cmd_read_magic,
            gpu_pkg::cmd_disable_output,
            gpu_pkg::cmd_enable_output: cmd_known = 1'b1;
            default:                    cmd_known = 1'b0;
        endcase
    end

    // the write state leads the bus by one edge, so the dummy state is left
    // one count early and the reply registers land on n=3+j
    always_comb
    begin
        next_state = state;
        if (cs)
            next_state = gpu_pkg::ph_idle;
        else
        begin
            case (state)
                gpu_pkg::ph_idle:    next_state = gpu_pkg::ph_command;
                gpu_pkg::ph_command:
                begin
                    if (cmd_known && full_cmd[7])
                        next_state = gpu_pkg::ph_read;
                    else if (cmd_known && full_cmd[6])
                        next_state = gpu_pkg::ph_write_dummy;
                    else
                        next_state = gpu_pkg::ph_done;   // undefined or no-data command
                end
                gpu_pkg::ph_read:    next_state = gpu_pkg::ph_read;   // runs until cs rises
                gpu_pkg::ph_write_dummy:
                begin
                    if (cnt == gpu_pkg::count_t'(`GPU_DUMMY_CYCLES - 2))
                        next_state = gpu_pkg::ph_write;
                end
                gpu_pkg::ph_write:
                begin
                    if ((cmd == gpu_pkg::cmd_read_status0 && cnt == status_last) ||
                        (cmd == gpu_pkg::cmd_read_magic && cnt == magic_last))
                        next_state = gpu_pkg::ph_done;
                end
                default:             next_state = gpu_pkg::ph_done;
            endcase
        end
        next_cnt = (next_state == state && !cs) ? cnt + 16'd1 : '0;
    end

    always_ff @(posedge sclk)
    begin
        rd_nibble <= data_in;   // lines up with the registered enables
        if (rst)
        begin
            state          <= gpu_pkg::ph_idle;
            cnt            <= '0;
            cmd_bits       <= '0;
            output_enabled <= 1'b0;
            phase_count    <= '0;
            pix_load       <= 1'b0;
            pal_load       <= 1'b0;
            pal_stream     <= 1'b0;
            resp_status    <= 1'b0;
            resp_magic     <= 1'b0;
        end
        else
        begin
            state <= next_state;
            cnt   <= next_cnt;
            if (!cs && (state == gpu_pkg::ph_idle || state == gpu_pkg::ph_command))
                cmd_bits <= full_cmd;

            // edge n=2, one cycle after the command completes
            if (!cs && state == gpu_pkg::ph_done && cnt == '0)
            begin
                if (cmd == gpu_pkg::cmd_enable_output)
                    output_enabled <= 1'b1;
                else if (cmd == gpu_pkg::cmd_disable_output)
                    output_enabled <= 1'b0;
            end

            phase_count <= (state == gpu_pkg::ph_read) ? cnt : next_cnt;
            pix_load    <= !cs && state == gpu_pkg::ph_read &&
                           cmd == gpu_pkg::cmd_fb_continuous_write;
            pal_load    <= !cs && state == gpu_pkg::ph_read && cmd == gpu_pkg::cmd_set_palette;
            pal_stream  <= next_state == gpu_pkg::ph_write && cmd == gpu_pkg::cmd_get_palette;
            resp_status <= next_state == gpu_pkg::ph_write && cmd == gpu_pkg::cmd_read_status0;
            resp_magic  <= next_state == gpu_pkg::ph_write && cmd == gpu_pkg::cmd_read_magic;
        end
    end

    // only one function may own the datapath
    assert property (@(posedge sclk) disable iff (rst)
        $onehot0({pix_load, pal_load, pal_stream, resp_status, resp_magic}));

    // a deselected slave always starts the next transaction from idle
    assert property (@(posedge sclk) disable iff (rst)
        cs |=> state == gpu_pkg::ph_idle);

endmodule

`default_nettype wire

//--- verilog/response_shifter.sv
`timescale 1ns/100ps
`default_nettype none
`include "gpu_macros.svh"

module response_shifter
(
    input  wire logic             sclk,
    input  wire logic             rst,
    input  wire logic             resp_status,
    input  wire logic             resp_magic,
    input  wire logic             pal_stream,
    input  wire gpu_pkg::count_t  phase_count,
    input  wire logic             hblank,
    input  wire logic             vblank,
    input  wire logic             output_enabled,
    input  wire gpu_pkg::nibble_t pal_nibble,
    output gpu_pkg::nibble_t      data_out,
    output logic                  data_oe
);

    gpu_pkg::resp_word_t shreg;
    gpu_pkg::resp_word_t load_word;
    logic [7:0]          status0;
    logic                word_active;

    assign status0     = {`GPU_STATUS_ID, hblank, vblank, output_enabled};
    assign word_active = resp_status | resp_magic;

    // status byte sits in the top half so both replies shift the same way
    assign load_word = resp_status ? {status0, 8'h00} : `GPU_MAGIC_NUMBER;

    always_ff @(posedge sclk)
    begin
        if (rst)
            data_oe <= 1'b0;
        else
            data_oe <= word_active | pal_stream;
    end

    always_ff @(posedge sclk)
    begin
        if (word_active)
        begin
            if (phase_count == '0)
            begin
                data_out <= load_word[15:12];   // flags sampled here, edge n=3
                shreg    <= {load_word[11:0], 4'h0};
            end
            else
            begin
                data_out <= shreg[15:12];
                shreg    <= {shreg[11:0], 4'h0};
            end
        end
        else if (pal_stream)
            data_out <= pal_nibble;
    end

    assert property (@(posedge sclk) disable iff (rst)
        !(resp_status || resp_magic || pal_stream) |=> !data_oe);

endmodule

`default_nettype wire
